/* Makefile */
# Verilator build, run, lint and clean for the Videopac glue testbench
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= vp_glue_tb
FILELIST  ?= vp_glue.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Verification failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A nonzero exit or the fail message in the log fails the run
run: build
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation run FAILED, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* source/cart_loader.sv */
// Download tracker that filters image writes, counts bytes and classifies the image size
`timescale 1ns/1ps

module cart_loader
	import vp_glue_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  reset,
	input  download_t             dl_i,
	output logic                  wr_en_o,
	output logic [IMG_ADDR_W-1:0] wr_addr_o,
	output logic [DATA_W-1:0]     wr_data_o,
	output size_class_t           size_class_o
);

	logic               active_q;
	logic               dl_start;
	logic               dl_end;
	logic               xrom_q;
	logic [COUNT_W-1:0] count_q;
	size_class_t        size_class_d;
	size_class_t        size_class_q;

	// Edges of the download window
	assign dl_start = dl_i.active & ~active_q;
	assign dl_end   = ~dl_i.active & active_q;

	// Only cartridge and XROM indices reach the image memory
	assign wr_en_o   = dl_i.active & dl_i.wr & (dl_i.index < 8'(MAX_CART_INDEX));
	assign wr_addr_o = dl_i.addr;
	assign wr_data_o = dl_i.data;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			active_q     <= 1'b0;
			xrom_q       <= 1'b0;
			count_q      <= '0;
			size_class_q <= SZ_SMALL;
		end else begin
			active_q <= dl_i.active;
			if (dl_start) begin
				// New image, restart the count
				count_q <= COUNT_W'(wr_en_o);
				xrom_q  <= (dl_i.index == 8'(XROM_INDEX));
			end else if (wr_en_o) begin
				count_q <= count_q + 1'b1;
			end
			// Size settles when the download ends
			if (dl_end)
				size_class_q <= size_class_d;
		end
	end

	// XROM wins, else exact size match, else small
	always_comb begin
		if (xrom_q)
			size_class_d = SZ_XROM;
		else if (count_q == COUNT_W'(SIZE_4K))
			size_class_d = SZ_4K;
		else if (count_q == COUNT_W'(SIZE_8K))
			size_class_d = SZ_8K;
		else if (count_q == COUNT_W'(SIZE_16K))
			size_class_d = SZ_16K;
		else
			size_class_d = SZ_SMALL;
	end

	assign size_class_o = size_class_q;

endmodule

/* source/cart_rom.sv */
// Cartridge image memory, 16 KiB, one write port and one registered read port
`timescale 1ns/1ps

module cart_rom
	import vp_glue_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  wr_en_i,
	input  logic [IMG_ADDR_W-1:0] wr_addr_i,
	input  logic [DATA_W-1:0]     wr_data_i,
	input  logic                  rd_en_i,
	input  logic [IMG_ADDR_W-1:0] rd_addr_i,
	output logic [DATA_W-1:0]     rd_data_o
);

	// Image bytes
	logic [DATA_W-1:0] mem [2**IMG_ADDR_W];
	logic [DATA_W-1:0] rd_data_q;

	// Download side
	always_ff @(posedge clk_sys) begin
		if (wr_en_i)
			mem[wr_addr_i] <= wr_data_i;
	end

	// Console side, holds between reads
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset)
			rd_data_q <= '0;
		else if (rd_en_i)
			rd_data_q <= mem[rd_addr_i];
	end

	assign rd_data_o = rd_data_q;

endmodule

/* source/clk_enable_gen.sv */
// CPU and VDC clock-enable dividers with NTSC and PAL periods
`timescale 1ns/1ps

module clk_enable_gen
	import vp_glue_pkg::*;
(
	input  logic clk_sys,
	input  logic reset,
	input  logic pal_i,
	output logic cpu_en_o,
	output logic vdc_en_o
);

	// Slot 0 drives the CPU enable, slot 1 the VDC enable
	logic             pal_q;
	logic             pal_change;
	logic [DIV_W-1:0] div_last [2];
	logic [DIV_W-1:0] ctr_q [2];
	logic [1:0]       en_q;

	// Previous standard, only compared against
	always_ff @(posedge clk_sys) begin
		pal_q <= pal_i;
	end

	// Standard switch restarts both dividers
	assign pal_change = (pal_i != pal_q);

	// Terminal counts for the current standard
	always_comb begin
		div_last[0] = pal_i ? DIV_W'(CPU_DIV_PAL - 1) : DIV_W'(CPU_DIV_NTSC - 1);
		div_last[1] = pal_i ? DIV_W'(VDC_DIV_PAL - 1) : DIV_W'(VDC_DIV_NTSC - 1);
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			ctr_q[0] <= '0;
			ctr_q[1] <= '0;
			en_q     <= '0;
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (pal_change) begin
					ctr_q[i] <= '0;
					en_q[i]  <= 1'b0;
				end else if (ctr_q[i] >= div_last[i]) begin
					// Wrap and pulse for one cycle
					ctr_q[i] <= '0;
					en_q[i]  <= 1'b1;
				end else begin
					ctr_q[i] <= ctr_q[i] + 1'b1;
					en_q[i]  <= 1'b0;
				end
			end
		end
	end

	assign cpu_en_o = en_q[0];
	assign vdc_en_o = en_q[1];

endmodule

/* source/palette_lut.sv */
// Colour-code to RGB lookup with palette select, greyscale and an output register
`timescale 1ns/1ps

module palette_lut
	import vp_glue_pkg::*;
(
	input  logic         clk_sys,
	input  logic         reset,
	input  colour_code_t colour_i,
	input  logic         palette_rgb_i,
	input  logic         mono_i,
	output rgb_t         pixel_o
);

	logic [3:0]  code;
	logic [23:0] tv_entry;
	logic [23:0] rgb_entry;
	rgb_t        colour;
	logic [15:0] grey_sum;
	logic [7:0]  grey;
	rgb_t        pixel_d;
	rgb_t        pixel_q;

	////////////////////////////////////////////////////////////////////////////
	// Lookup

	// Code bits r, g, b, luma form the index
	assign code = colour_i;

	assign tv_entry  = PALETTE_TV[code*24 +: 24];
	assign rgb_entry = PALETTE_RGB[code*24 +: 24];

	// Palette select
	assign colour = palette_rgb_i ? rgb_t'(rgb_entry) : rgb_t'(tv_entry);

	////////////////////////////////////////////////////////////////////////////
	// Greyscale

	// Weighted sum fits 16 bits, weights add to 256
	assign grey_sum = 16'(GREY_R) * 16'(colour.r)
	                + 16'(GREY_G) * 16'(colour.g)
	                + 16'(GREY_B) * 16'(colour.b);

	// Drop the weight scale
	assign grey = grey_sum[15:8];

	always_comb begin
		if (mono_i) begin
			pixel_d.r = grey;
			pixel_d.g = grey;
			pixel_d.b = grey;
		end else begin
			pixel_d = colour;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Output register

	// Black out of reset
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset)
			pixel_q <= '0;
		else
			pixel_q <= pixel_d;
	end

	assign pixel_o = pixel_q;

endmodule

/* source/rom_bank_map.sv */
// Bank mapper from the console cartridge bus to an image address and read enable
`timescale 1ns/1ps

module rom_bank_map
	import vp_glue_pkg::*;
(
	input  cart_bus_t             cart_i,
	input  size_class_t           size_class_i,
	output logic [IMG_ADDR_W-1:0] rd_addr_o,
	output logic                  rd_en_o
);

	// Bank layout per size class, bit 10 unused below 16K
	always_comb begin
		case (size_class_i)
			SZ_4K:   rd_addr_o = {2'b00, cart_i.bs0, cart_i.addr[11], cart_i.addr[9:0]};
			SZ_8K:   rd_addr_o = {1'b0, cart_i.bs1, cart_i.bs0, cart_i.addr[11], cart_i.addr[9:0]};
			SZ_16K:  rd_addr_o = {cart_i.bs1, cart_i.bs0, cart_i.addr};
			SZ_XROM: rd_addr_o = {2'b00, cart_i.addr};
			default: rd_addr_o = {3'b000, cart_i.addr[11], cart_i.addr[9:0]};
		endcase
	end

	// XROM reads on psen_n high unless cs_n and bs0 are both set
	always_comb begin
		if (size_class_i == SZ_XROM)
			rd_en_o = cart_i.psen_n & ~(cart_i.cs_n & cart_i.bs0);
		else
			rd_en_o = ~cart_i.psen_n;
	end

endmodule

/* source/vp_glue_pkg.sv */
// Shared widths, divider counts, size classes, palettes and bus structs of the Videopac glue
package vp_glue_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths

	localparam int CART_ADDR_W = 12;
	localparam int IMG_ADDR_W  = 14;
	localparam int DATA_W      = 8;
	// Image byte counter, wide enough to go past 16K
	localparam int COUNT_W     = 16;
	// Clock-enable divider counters
	localparam int DIV_W       = 4;

	// Clocks per enable, NTSC and PAL
	localparam int CPU_DIV_NTSC = 8;
	localparam int CPU_DIV_PAL  = 12;
	localparam int VDC_DIV_NTSC = 6;
	localparam int VDC_DIV_PAL  = 10;

	// Image sizes that select a bank layout
	localparam int SIZE_4K  = 4096;
	localparam int SIZE_8K  = 8192;
	localparam int SIZE_16K = 16384;

	// Download indices
	localparam int XROM_INDEX     = 2;
	localparam int MAX_CART_INDEX = 3;

	// Luma weights, sum is 256
	localparam int GREY_R = 77;
	localparam int GREY_G = 150;
	localparam int GREY_B = 29;

	////////////////////////////////////////////////////////////////////////////
	// Palettes, entry 0 in the low 24 bits

	// Calibrated TV (RF) colours
	localparam logic [16*24-1:0] PALETTE_TV = {
		24'hffffff, 24'hcecece, 24'hc6b86a, 24'h77670b,  // 15..12
		24'hdc84e8, 24'h94309f, 24'hc75151, 24'h790000,  // 11..8
		24'h77e6eb, 24'h2aaabe, 24'h56c469, 24'h006d07,  // 7..4
		24'h5c80f6, 24'h1a37be, 24'h676767, 24'h000000   // 3..0
	};

	// Plain RGB colours
	localparam logic [16*24-1:0] PALETTE_RGB = {
		24'hffffff, 24'hb6b6b6, 24'hffff49, 24'hb6b600,  // 15..12
		24'hff49ff, 24'hb600b6, 24'hff4949, 24'hb60000,  // 11..8
		24'h49ffff, 24'h00b6c9, 24'h49ff49, 24'h00b601,  // 7..4
		24'h4949ff, 24'h0000b6, 24'h494949, 24'h000000   // 3..0
	};

	////////////////////////////////////////////////////////////////////////////
	// Bus types

	// Host download bus
	typedef struct packed {
		logic                  active;
		logic                  wr;
		logic [7:0]            index;
		logic [IMG_ADDR_W-1:0] addr;
		logic [DATA_W-1:0]     data;
	} download_t;

	// Console cartridge bus, strobes active low
	typedef struct packed {
		logic [CART_ADDR_W-1:0] addr;
		logic                   bs0;
		logic                   bs1;
		logic                   psen_n;
		logic                   cs_n;
	} cart_bus_t;

	// VDC colour code, packed value is the palette index
	typedef struct packed {
		logic r;
		logic g;
		logic b;
		logic luma;
	} colour_code_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	typedef enum logic [2:0] {
		SZ_SMALL,
		SZ_4K,
		SZ_8K,
		SZ_16K,
		SZ_XROM
	} size_class_t;

endpackage

/* source/vp_glue_top.sv */
// Console-side glue joining download loader, bank mapper, image memory, clock enables and palette
`timescale 1ns/1ps

module vp_glue_top
	import vp_glue_pkg::*;
(
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              pal_i,
	input  logic              palette_rgb_i,
	input  logic              mono_i,
	input  download_t         dl_i,
	input  cart_bus_t         cart_i,
	input  colour_code_t      colour_i,
	output logic              cpu_en_o,
	output logic              vdc_en_o,
	output logic [DATA_W-1:0] cart_data_o,
	output rgb_t              pixel_o
);

	// Loader to memory and mapper
	logic                  wr_en;
	logic [IMG_ADDR_W-1:0] wr_addr;
	logic [DATA_W-1:0]     wr_data;
	size_class_t           size_class;

	// Mapper to memory
	logic [IMG_ADDR_W-1:0] rd_addr;
	logic                  rd_en;

	////////////////////////////////////////////////////////////////////////////
	// Timing

	clk_enable_gen clk_en0 (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.pal_i    (pal_i),
		.cpu_en_o (cpu_en_o),
		.vdc_en_o (vdc_en_o)
	);

	////////////////////////////////////////////////////////////////////////////
	// Cartridge path

	cart_loader loader0 (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl_i         (dl_i),
		.wr_en_o      (wr_en),
		.wr_addr_o    (wr_addr),
		.wr_data_o    (wr_data),
		.size_class_o (size_class)
	);

	rom_bank_map map0 (
		.cart_i       (cart_i),
		.size_class_i (size_class),
		.rd_addr_o    (rd_addr),
		.rd_en_o      (rd_en)
	);

	cart_rom rom0 (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.wr_en_i   (wr_en),
		.wr_addr_i (wr_addr),
		.wr_data_i (wr_data),
		.rd_en_i   (rd_en),
		.rd_addr_i (rd_addr),
		.rd_data_o (cart_data_o)
	);

	////////////////////////////////////////////////////////////////////////////
	// Video

	palette_lut palette0 (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.colour_i      (colour_i),
		.palette_rgb_i (palette_rgb_i),
		.mono_i        (mono_i),
		.pixel_o       (pixel_o)
	);

endmodule

/* testbench/vp_glue_chk.sv */
// Bound assertions on the clock-enable pulses and the palette output register
`timescale 1ns/1ps

module vp_glue_chk
	import vp_glue_pkg::*;
(
	input logic clk_sys,
	input logic reset,
	input logic cpu_en_i,
	input logic vdc_en_i,
	input rgb_t pixel_i
);

	// CPU enable is a one-cycle pulse
	cpu_en_single: assert property (@(posedge clk_sys) disable iff (reset)
		cpu_en_i |=> !cpu_en_i)
		else $error("cpu_en_o stayed high for two cycles in a row");

	// Enables held off in reset
	en_low_in_reset: assert property (@(posedge clk_sys) reset |-> !cpu_en_i && !vdc_en_i)
		else $error("clock enable high while reset is asserted");

	// Output register leaves reset black
	pixel_black: assert property (@(posedge clk_sys) $fell(reset) |-> pixel_i == '0)
		else $error("pixel_o not black in the cycle after reset");

endmodule

// Unused checker inputs tied off per target
bind clk_enable_gen vp_glue_chk enable_chk0 (
	.clk_sys  (clk_sys),
	.reset    (reset),
	.cpu_en_i (cpu_en_o),
	.vdc_en_i (vdc_en_o),
	.pixel_i  (24'h000000)
);

bind palette_lut vp_glue_chk palette_chk0 (
	.clk_sys  (clk_sys),
	.reset    (reset),
	.cpu_en_i (1'b0),
	.vdc_en_i (1'b0),
	.pixel_i  (pixel_o)
);

/* testbench/vp_glue_tb.sv */
// Testbench for the Videopac glue covering image loads, banked reads, clock enables and palette
`timescale 1ns/1ps

module vp_glue_tb
	import vp_glue_pkg::*;
();

	localparam int NUM_ROWS      = 5;
	localparam int ENABLE_WINDOW = 240;
	localparam int PULSE_TIMEOUT = 64;

	typedef struct packed {
		logic [15:0] length;
		logic [7:0]  index;
		logic [15:0] reads;
		logic        palette_rgb;
		logic        mono;
	} row_t;

	// Image length, download index, reads, palette select, mono
	row_t rows [NUM_ROWS] = '{
		'{16'd4096,  8'd2, 16'd300, 1'b0, 1'b0},  // XROM
		'{16'd2048,  8'd0, 16'd300, 1'b1, 1'b0},  // SMALL
		'{16'd4096,  8'd0, 16'd300, 1'b0, 1'b1},  // 4K
		'{16'd8192,  8'd1, 16'd300, 1'b1, 1'b1},  // 8K
		'{16'd16384, 8'd0, 16'd300, 1'b0, 1'b0}   // 16K
	};

	logic              clk_sys;
	logic              reset;
	logic              pal;
	logic              palette_rgb;
	logic              mono;
	download_t         dl;
	cart_bus_t         cart;
	colour_code_t      colour;
	logic              cpu_en;
	logic              vdc_en;
	logic [DATA_W-1:0] cart_data;
	rgb_t              pixel;

	// Copy of the image as the host wrote it
	logic [DATA_W-1:0] image [2**IMG_ADDR_W];
	logic [31:0]       rng_state;
	int                errors;

	vp_glue_top dut0 (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.pal_i         (pal),
		.palette_rgb_i (palette_rgb),
		.mono_i        (mono),
		.dl_i          (dl),
		.cart_i        (cart),
		.colour_i      (colour),
		.cpu_en_o      (cpu_en),
		.vdc_en_o      (vdc_en),
		.cart_data_o   (cart_data),
		.pixel_o       (pixel)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers

	// 32-bit xorshift
	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			errors++;
			$display("Mismatch at %0t: %s got 0x%0h, expected 0x%0h",
				$time, name, got, expected);
		end
	endtask

	// Size class the loader should settle on
	function automatic size_class_t class_of_row(input row_t row);
		if (row.index == 8'(XROM_INDEX))
			return SZ_XROM;
		case (row.length)
			16'd4096:  return SZ_4K;
			16'd8192:  return SZ_8K;
			16'd16384: return SZ_16K;
			default:   return SZ_SMALL;
		endcase
	endfunction

	// Image offset from the bank rule of each size class
	function automatic logic [IMG_ADDR_W-1:0] expected_addr(input size_class_t cls,
		input cart_bus_t bus);
		int low;
		int offset;
		// Bus address bit 10 is skipped below 16K
		low = int'(bus.addr[9:0]) + (bus.addr[11] ? 1024 : 0);
		case (cls)
			SZ_4K:   offset = low + (bus.bs0 ? 2048 : 0);
			SZ_8K:   offset = low + (bus.bs0 ? 2048 : 0) + (bus.bs1 ? 4096 : 0);
			SZ_16K:  offset = int'(bus.addr) + (bus.bs0 ? 4096 : 0) + (bus.bs1 ? 8192 : 0);
			SZ_XROM: offset = int'(bus.addr);
			default: offset = low;
		endcase
		return IMG_ADDR_W'(offset);
	endfunction

	// XROM needs psen_n high and not both cs_n and bs0 high
	function automatic logic read_enabled(input size_class_t cls, input cart_bus_t bus);
		logic blocked;
		blocked = (bus.cs_n == 1'b1) && (bus.bs0 == 1'b1);
		if (cls == SZ_XROM)
			return (bus.psen_n == 1'b1) && !blocked;
		return bus.psen_n == 1'b0;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stimulus tasks enter and leave on a falling edge

	task automatic load_image(input row_t row);
		// One idle cycle so the loader sees the start
		dl.active = 1'b1;
		dl.index  = row.index;
		dl.wr     = 1'b0;
		for (int a = 0; a < int'(row.length); a++) begin
			@(negedge clk_sys);
			dl.wr   = 1'b1;
			dl.addr = IMG_ADDR_W'(a);
			dl.data = 8'(next_random());
			image[dl.addr] = dl.data;
		end
		@(negedge clk_sys);
		dl = '0;
		// Size class updates on the edge after active falls
		@(negedge clk_sys);
	endtask

	task automatic check_reads(input row_t row);
		size_class_t       cls;
		cart_bus_t         bus;
		logic [31:0]       r;
		logic              enabled;
		logic [DATA_W-1:0] held;
		cls  = class_of_row(row);
		held = '0;
		for (int k = 0; k < int'(row.reads); k++) begin
			r          = next_random();
			bus.addr   = r[11:0];
			bus.bs0    = r[12];
			bus.bs1    = r[13];
			bus.psen_n = r[14];
			bus.cs_n   = r[15];
			// First access always reads, so the held byte is known
			if (k == 0) begin
				bus.psen_n = (cls == SZ_XROM);
				bus.cs_n   = 1'b0;
			end
			enabled = read_enabled(cls, bus);
			cart    = bus;
			@(negedge clk_sys);
			if (enabled)
				held = image[expected_addr(cls, bus)];
			compare_value("cart_data_o", 32'(cart_data), 32'(held));
		end
		cart.psen_n = 1'b1;
		cart.cs_n   = 1'b1;
	endtask

	task automatic check_palette(input row_t row);
		logic [23:0] entry;
		rgb_t        expected;
		int          grey;
		palette_rgb = row.palette_rgb;
		mono        = row.mono;
		for (int code = 0; code < 16; code++) begin
			colour = colour_code_t'(4'(code));
			entry  = row.palette_rgb ? PALETTE_RGB[code*24 +: 24] : PALETTE_TV[code*24 +: 24];
			expected = rgb_t'(entry);
			if (row.mono) begin
				grey = (GREY_R * int'(expected.r) + GREY_G * int'(expected.g)
					+ GREY_B * int'(expected.b)) / 256;
				expected = {8'(grey), 8'(grey), 8'(grey)};
			end
			@(negedge clk_sys);
			compare_value("pixel_o", 32'(pixel), 32'(expected));
		end
	endtask

	// Sync to a CPU pulse, then count both enables over a fixed window
	task automatic count_enables(input string mode, input int cpu_div, input int vdc_div);
		int waited;
		int cpu_count;
		int vdc_count;
		int cpu_last;
		int vdc_last;
		waited    = 0;
		cpu_count = 0;
		vdc_count = 0;
		cpu_last  = -1;
		vdc_last  = -1;
		while (cpu_en !== 1'b1 && waited < PULSE_TIMEOUT) begin
			@(negedge clk_sys);
			waited++;
		end
		if (cpu_en !== 1'b1) begin
			errors++;
			$display("Timeout: no cpu_en_o pulse within %0d cycles in %s mode",
				PULSE_TIMEOUT, mode);
		end
		for (int cycle = 0; cycle < ENABLE_WINDOW; cycle++) begin
			@(negedge clk_sys);
			if (cpu_en) begin
				if (cpu_last >= 0)
					compare_value("cpu_en_o spacing", 32'(cycle - cpu_last), 32'(cpu_div));
				cpu_last = cycle;
				cpu_count++;
			end
			if (vdc_en) begin
				if (vdc_last >= 0)
					compare_value("vdc_en_o spacing", 32'(cycle - vdc_last), 32'(vdc_div));
				vdc_last = cycle;
				vdc_count++;
			end
		end
		compare_value("cpu_en_o count", 32'(cpu_count), 32'(ENABLE_WINDOW / cpu_div));
		compare_value("vdc_en_o count", 32'(vdc_count), 32'(ENABLE_WINDOW / vdc_div));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		rng_state   = 32'd62936;
		errors      = 0;
		reset       = 1'b1;
		pal         = 1'b0;
		palette_rgb = 1'b0;
		mono        = 1'b0;
		dl          = '0;
		cart        = '0;
		cart.psen_n = 1'b1;
		cart.cs_n   = 1'b1;
		colour      = '0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		compare_value("cart_data_o", 32'(cart_data), 32'h0);
		compare_value("pixel_o", 32'(pixel), 32'h0);
		for (int i = 0; i < NUM_ROWS; i++) begin
			load_image(rows[i]);
			check_reads(rows[i]);
			check_palette(rows[i]);
		end
		// NTSC periods, then PAL after a standard switch
		count_enables("NTSC", CPU_DIV_NTSC, VDC_DIV_NTSC);
		pal = 1'b1;
		@(negedge clk_sys);
		count_enables("PAL", CPU_DIV_PAL, VDC_DIV_PAL);
		$display("Checks done with %0d error(s)", errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

/* vp_glue.f */
source/vp_glue_pkg.sv
source/clk_enable_gen.sv
source/cart_loader.sv
source/cart_rom.sv
source/rom_bank_map.sv
source/palette_lut.sv
source/vp_glue_top.sv
testbench/vp_glue_chk.sv
testbench/vp_glue_tb.sv
